// ==== Makefile ====
# Verilator simulation of the control unit testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tbControlUnit -f tb.f -o simControlUnit

run: compile
	./obj_dir/simControlUnit

clean:
	rm -rf obj_dir

// ==== controlOutputs.sv ====
/*
 * Control output table.
 * Moore decode of the FSM state into every datapath control signal.
 * Anything a state does not set stays at its zero encoding.
 */
`timescale 1ns/10ps

module controlOutputs (
	input  controlPkg::stateT state,
	output logic [2:0] srcAddressMem,
	output logic writeMdr,
	output logic irWrite,
	output logic [2:0] regDst,
	output logic regWrite,
	output logic writeA,
	output logic writeB,
	output logic [1:0] aluSrcA,
	output logic [2:0] aluSrcB,
	output logic [2:0] aluOp,
	output logic writeAluOut,
	output logic epcWrite,
	output logic [1:0] pcSource,
	output logic pcWrite,
	output logic [2:0] memToReg,
	output logic [1:0] disRegEntry,
	output logic [1:0] disRegShamt,
	output logic [2:0] disRegOp
);
	import controlPkg::*;

	always_comb begin
		srcAddressMem = addrPc;
		writeMdr = 1'b0;
		irWrite = 1'b0;
		regDst = dstRt;
		regWrite = 1'b0;
		writeA = 1'b0;
		writeB = 1'b0;
		aluSrcA = aluAPc;
		aluSrcB = aluBRegB;
		aluOp = aluLoad;
		writeAluOut = 1'b0;
		epcWrite = 1'b0;
		pcSource = pcAluResult;
		pcWrite = 1'b0;
		memToReg = wbAluOut;
		disRegEntry = shInRegB;
		disRegShamt = shAmtField;
		disRegOp = shNone;

		case (state)
			stReset: begin // stack pointer init
				regWrite = 1'b1;
				regDst = dstSp;
				memToReg = wbStackTop;
			end
			stFetch: begin // pc + 4 while memory reads
				writeMdr = 1'b1;
				pcWrite = 1'b1;
				aluSrcB = aluBFour;
				aluOp = aluAdd;
			end
			stIrLoad: irWrite = 1'b1;
			stDecode: begin // branch target precomputed
				writeA = 1'b1;
				writeB = 1'b1;
				writeAluOut = 1'b1;
				aluSrcB = aluBBranchOff;
				aluOp = aluAdd;
			end
			stAluAdd, stAluSub, stAluAnd, stAluSlt: begin
				aluSrcA = aluARegA;
				aluSrcB = aluBRegB;
				writeAluOut = 1'b1;
				case (state)
					stAluAdd: aluOp = aluAdd;
					stAluSub: aluOp = aluSub;
					stAluAnd: aluOp = aluAnd;
					default: begin
						aluOp = aluCompare;
						regDst = dstRd;
					end
				endcase
			end
			stAddi, stAddiu: begin
				aluSrcA = aluARegA;
				aluSrcB = (state == stAddi) ? aluBSignImm : aluBZeroImm;
				aluOp = aluAdd;
				writeAluOut = 1'b1;
			end
			stJr: begin
				aluSrcA = aluARegA;
				aluSrcB = aluBRegB;
				aluOp = aluLoad;
				writeAluOut = 1'b1;
				pcWrite = 1'b1;
				pcSource = pcAluResult; // straight from the ALU
			end
			stBreak: begin // undo the fetch increment
				aluSrcA = aluAPc;
				aluSrcB = aluBFour;
				aluOp = aluSub;
				pcWrite = 1'b1;
			end
			stWriteAluRd: begin
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbAluOut;
			end
			stWriteImmRt: begin
				regWrite = 1'b1;
				regDst = dstRt;
				memToReg = wbAluOut;
			end
			stWriteSltRd: begin
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbLess;
			end
			stWriteShiftRd: begin
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbShift;
			end
			stWriteRa: begin
				regWrite = 1'b1;
				regDst = dstRa;
				memToReg = wbPc;
			end
			stOverflow: begin // epc gets pc - 4
				aluSrcB = aluBFour;
				aluOp = aluSub;
				writeAluOut = 1'b1;
				epcWrite = 1'b1;
			end
			stCauseLoad: begin
				srcAddressMem = addrCause;
				writeMdr = 1'b1;
				aluSrcA = aluAExcBase;
				writeAluOut = 1'b1;
			end
			stCauseJump, stJump, stBranch: begin
				pcWrite = 1'b1;
				pcSource = pcAluOut;
			end
			stCompare: begin
				aluSrcA = aluARegA;
				aluOp = aluCompare;
			end
			stJalLink: memToReg = wbPc;
			stJalWait2: writeMdr = 1'b1;
			stShLoadSll, stShLoadSra, stShLoadSrl: begin
				disRegOp = shLoad;
				disRegEntry = shInRegB;
			end
			stShLoadSllv, stShLoadSrav: begin
				disRegOp = shLoad;
				disRegEntry = shInRegA;
			end
			stShSll, stShSra, stShSrl: begin // amount from the shamt field
				disRegEntry = shInRegB;
				disRegShamt = shAmtField;
				case (state)
					stShSll: disRegOp = shLeft;
					stShSra: disRegOp = shRightArith;
					default: disRegOp = shRightLogic;
				endcase
			end
			stShSllv, stShSrav: begin
				disRegEntry = shInRegA;
				disRegShamt = shAmtReg;
				disRegOp = (state == stShSllv) ? shLeft : shRightArith;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== controlPkg.sv ====
/*
 * Control package for the multicycle MIPS-like control unit.
 * Holds the opcode and function codes, the instruction classes,
 * the FSM state encoding and every datapath select encoding.
 */
package controlPkg;

	// opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opBle = 6'h06;
	localparam logic [5:0] opBgt = 6'h07;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;

	// R-type function codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnSllv = 6'h04;
	localparam logic [5:0] fnSrav = 6'h07;
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnBreak = 6'h0d;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnSlt = 6'h2a;

	localparam logic [1:0] aluAPc = 2'd0;
	localparam logic [1:0] aluARegA = 2'd1;
	localparam logic [1:0] aluAExcBase = 2'd3; // exception vector base

	localparam logic [2:0] aluBRegB = 3'd0;
	localparam logic [2:0] aluBFour = 3'd1;
	localparam logic [2:0] aluBSignImm = 3'd2;
	localparam logic [2:0] aluBBranchOff = 3'd3; // sign-extended and shifted by 2
	localparam logic [2:0] aluBZeroImm = 3'd4;

	localparam logic [2:0] aluLoad = 3'd0; // pass A through
	localparam logic [2:0] aluAdd = 3'd1;
	localparam logic [2:0] aluSub = 3'd2;
	localparam logic [2:0] aluAnd = 3'd3;
	localparam logic [2:0] aluCompare = 3'd7;

	localparam logic [2:0] dstRt = 3'd0;
	localparam logic [2:0] dstRd = 3'd1;
	localparam logic [2:0] dstRa = 3'd2;
	localparam logic [2:0] dstSp = 3'd3;

	localparam logic [2:0] wbAluOut = 3'd0;
	localparam logic [2:0] wbPc = 3'd1;
	localparam logic [2:0] wbShift = 3'd4;
	localparam logic [2:0] wbLess = 3'd6;
	localparam logic [2:0] wbStackTop = 3'd7; // initial stack pointer

	localparam logic [1:0] pcAluResult = 2'd0;
	localparam logic [1:0] pcAluOut = 2'd1;

	localparam logic [2:0] addrPc = 3'd0;
	localparam logic [2:0] addrCause = 3'd3;

	// shift register unit
	localparam logic [1:0] shInRegB = 2'd0;
	localparam logic [1:0] shInRegA = 2'd1;
	localparam logic [1:0] shAmtField = 2'd0;
	localparam logic [1:0] shAmtReg = 2'd1;
	localparam logic [2:0] shNone = 3'd0;
	localparam logic [2:0] shLoad = 3'd1;
	localparam logic [2:0] shLeft = 3'd2;
	localparam logic [2:0] shRightLogic = 3'd3;
	localparam logic [2:0] shRightArith = 3'd4;

	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAnd, clsSlt, clsJr, clsBreak,
		clsAddi, clsAddiu, clsJ, clsJal,
		clsBeq, clsBne, clsBle, clsBgt,
		clsSll, clsSllv, clsSra, clsSrav, clsSrl,
		clsUnknown
	} instrClassT;

	typedef enum logic [6:0] {
		stReset, stFetch, stWait, stIrLoad, stDecode,
		stAluAdd, stAluSub, stAluAnd, stAluSlt, stAddi, stAddiu, stJr, stBreak,
		stWriteAluRd, stWriteImmRt, stWriteSltRd,
		stOverflow, stCauseLoad, stCauseJump,
		stJump, stJalLink, stJalWait1, stJalWait2, stWriteRa,
		stCompare, stBranch,
		stShLoadSll, stShLoadSllv, stShLoadSra, stShLoadSrav, stShLoadSrl,
		stShSll, stShSllv, stShSra, stShSrav, stShSrl, stWriteShiftRd
	} stateT;

endpackage

// ==== controlSequencer.sv ====
/*
 * Control sequencer.
 * Holds the FSM state and computes the next state from the decoded
 * class, the ALU overflow flag and the comparator flags.
 */
`timescale 1ns/10ps

module controlSequencer (
	input  logic clk,
	input  logic reset,
	input  controlPkg::instrClassT instrClass,
	input  logic overflow,
	input  logic eq,
	input  logic gt,
	output controlPkg::stateT state
);
	import controlPkg::*;

	stateT nextState;
	instrClassT latchedClass; // class seen at decode
	logic branchTaken;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	// keeps the branch kind for the compare cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			latchedClass <= clsUnknown;
		end else if (state == stDecode) begin
			latchedClass <= instrClass;
		end
	end

	always_comb begin
		case (latchedClass)
			clsBeq: branchTaken = eq;
			clsBne: branchTaken = !eq;
			clsBle: branchTaken = !gt;
			clsBgt: branchTaken = gt;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		nextState = stFetch; // terminal states return here
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stWait;
			stWait: nextState = stIrLoad;
			stIrLoad: nextState = stDecode;
			stDecode: begin
				case (instrClass)
					clsAdd: nextState = stAluAdd;
					clsSub: nextState = stAluSub;
					clsAnd: nextState = stAluAnd;
					clsSlt: nextState = stAluSlt;
					clsJr: nextState = stJr;
					clsBreak: nextState = stBreak;
					clsAddi: nextState = stAddi;
					clsAddiu: nextState = stAddiu;
					clsJ: nextState = stJump;
					clsJal: nextState = stJalLink;
					clsBeq, clsBne, clsBle, clsBgt: nextState = stCompare;
					clsSll: nextState = stShLoadSll;
					clsSllv: nextState = stShLoadSllv;
					clsSra: nextState = stShLoadSra;
					clsSrav: nextState = stShLoadSrav;
					clsSrl: nextState = stShLoadSrl;
					default: nextState = stFetch; // unknown code
				endcase
			end
			stAluAdd, stAluSub: nextState = overflow ? stOverflow : stWriteAluRd;
			stAddi, stAddiu: nextState = overflow ? stOverflow : stWriteImmRt;
			stAluAnd: nextState = stWriteAluRd;
			stAluSlt: nextState = stWriteSltRd;
			stCompare: nextState = branchTaken ? stBranch : stFetch;
			stOverflow: nextState = stCauseLoad;
			stCauseLoad: nextState = stCauseJump;
			// jal links first, then jumps
			stJalLink: nextState = stJalWait1;
			stJalWait1: nextState = stJalWait2;
			stJalWait2: nextState = stWriteRa;
			stWriteRa: nextState = stJump;
			stShLoadSll: nextState = stShSll;
			stShLoadSllv: nextState = stShSllv;
			stShLoadSra: nextState = stShSra;
			stShLoadSrav: nextState = stShSrav;
			stShLoadSrl: nextState = stShSrl;
			stShSll, stShSllv, stShSra, stShSrav, stShSrl: nextState = stWriteShiftRd;
			default: nextState = stFetch;
		endcase
	end

endmodule

// ==== controlUnit.sv ====
/*
 * Multicycle control unit, top level.
 * Connects the instruction decoder, the sequencer FSM and the
 * Moore output table.
 */
`timescale 1ns/10ps

module controlUnit (
	input  logic clk,
	input  logic reset,
	input  logic [5:0] opCode,
	input  logic [5:0] func,
	input  logic overflow,
	input  logic eq,
	input  logic gt,
	output logic [2:0] srcAddressMem,
	output logic writeMdr,
	output logic irWrite,
	output logic [2:0] regDst,
	output logic regWrite,
	output logic writeA,
	output logic writeB,
	output logic [1:0] aluSrcA,
	output logic [2:0] aluSrcB,
	output logic [2:0] aluOp,
	output logic writeAluOut,
	output logic epcWrite,
	output logic [1:0] pcSource,
	output logic pcWrite,
	output logic [2:0] memToReg,
	output logic [1:0] disRegEntry,
	output logic [1:0] disRegShamt,
	output logic [2:0] disRegOp
);
	import controlPkg::*;

	instrClassT instrClass;
	stateT state;

	instrDecoder decoder_i (
		.opCode(opCode),
		.func(func),
		.instrClass(instrClass)
	);

	controlSequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.overflow(overflow),
		.eq(eq),
		.gt(gt),
		.state(state)
	);

	controlOutputs outputs_i (
		.state(state),
		.srcAddressMem(srcAddressMem),
		.writeMdr(writeMdr),
		.irWrite(irWrite),
		.regDst(regDst),
		.regWrite(regWrite),
		.writeA(writeA),
		.writeB(writeB),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.writeAluOut(writeAluOut),
		.epcWrite(epcWrite),
		.pcSource(pcSource),
		.pcWrite(pcWrite),
		.memToReg(memToReg),
		.disRegEntry(disRegEntry),
		.disRegShamt(disRegShamt),
		.disRegOp(disRegOp)
	);

endmodule

// ==== instrDecoder.sv ====
/*
 * Instruction decoder.
 * Maps the opcode, and for R-type the function code, onto an
 * instruction class. Codes outside the supported set give clsUnknown.
 */
`timescale 1ns/10ps

module instrDecoder (
	input  logic [5:0] opCode,
	input  logic [5:0] func,
	output controlPkg::instrClassT instrClass
);
	import controlPkg::*;

	always_comb begin
		instrClass = clsUnknown;
		case (opCode)
			opRType: begin
				case (func)
					fnAdd: instrClass = clsAdd;
					fnSub: instrClass = clsSub;
					fnAnd: instrClass = clsAnd;
					fnSlt: instrClass = clsSlt;
					fnJr: instrClass = clsJr;
					fnBreak: instrClass = clsBreak;
					fnSll: instrClass = clsSll;
					fnSllv: instrClass = clsSllv;
					fnSra: instrClass = clsSra;
					fnSrav: instrClass = clsSrav;
					fnSrl: instrClass = clsSrl;
					default: instrClass = clsUnknown; // unsupported function
				endcase
			end
			opAddi: instrClass = clsAddi;
			opAddiu: instrClass = clsAddiu;
			opJ: instrClass = clsJ;
			opJal: instrClass = clsJal;
			opBeq: instrClass = clsBeq;
			opBne: instrClass = clsBne;
			opBle: instrClass = clsBle;
			opBgt: instrClass = clsBgt;
			default: instrClass = clsUnknown;
		endcase
	end

endmodule

// ==== tb.f ====
controlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlOutputs.sv
controlUnit.sv
tbControlUnit.sv

// ==== tbControlUnit.sv ====
/*
 * Testbench for the multicycle control unit.
 * Issues random instructions and flag values, queues the control outputs
 * expected in every cycle and checks the DUT against them with assertions.
 */
`timescale 1ns/10ps

module tbControlUnit;
	import controlPkg::*;

	localparam int numInstr = 300;
	localparam int timeoutCycles = numInstr * 9 + 100;

	// all DUT outputs in port order
	typedef struct packed {
		logic [2:0] srcAddressMem;
		logic writeMdr;
		logic irWrite;
		logic [2:0] regDst;
		logic regWrite;
		logic writeA;
		logic writeB;
		logic [1:0] aluSrcA;
		logic [2:0] aluSrcB;
		logic [2:0] aluOp;
		logic writeAluOut;
		logic epcWrite;
		logic [1:0] pcSource;
		logic pcWrite;
		logic [2:0] memToReg;
		logic [1:0] disRegEntry;
		logic [1:0] disRegShamt;
		logic [2:0] disRegOp;
	} ctrlVecT;

	typedef enum logic [4:0] {
		kAdd, kSub, kAnd, kSlt, kJr, kBreak, kAddi, kAddiu, kJ, kJal,
		kBeq, kBne, kBle, kBgt, kSll, kSllv, kSra, kSrav, kSrl, kUnknown
	} instrKindT;

	logic clk;
	logic reset;
	logic [5:0] opCode, func;
	logic overflow, eq, gt;
	logic [2:0] srcAddressMem, regDst, aluSrcB, aluOp, memToReg, disRegOp;
	logic [1:0] aluSrcA, pcSource, disRegEntry, disRegShamt;
	logic writeMdr, irWrite, regWrite, writeA, writeB, writeAluOut, epcWrite, pcWrite;

	ctrlVecT actual;
	ctrlVecT expected; // due in the current cycle
	ctrlVecT pending[$]; // one entry per coming cycle
	int cycles = 0;

	controlUnit dut_i (.*);

	assign actual = {srcAddressMem, writeMdr, irWrite, regDst, regWrite, writeA, writeB,
		aluSrcA, aluSrcB, aluOp, writeAluOut, epcWrite, pcSource, pcWrite, memToReg,
		disRegEntry, disRegShamt, disRegOp};

	localparam ctrlVecT quietV = '0;
	localparam ctrlVecT fetchV = '{writeMdr: 1'b1, pcWrite: 1'b1, aluSrcB: aluBFour,
		aluOp: aluAdd, default: '0};
	localparam ctrlVecT irLoadV = '{irWrite: 1'b1, default: '0};
	localparam ctrlVecT decodeV = '{writeA: 1'b1, writeB: 1'b1, writeAluOut: 1'b1,
		aluSrcB: aluBBranchOff, aluOp: aluAdd, default: '0};
	localparam ctrlVecT pcJumpV = '{pcWrite: 1'b1, pcSource: pcAluOut, default: '0};
	localparam ctrlVecT compareV = '{aluSrcA: aluARegA, aluOp: aluCompare, default: '0};
	localparam ctrlVecT overflowV = '{aluSrcB: aluBFour, aluOp: aluSub, writeAluOut: 1'b1,
		epcWrite: 1'b1, default: '0};
	localparam ctrlVecT causeLoadV = '{srcAddressMem: addrCause, writeMdr: 1'b1,
		aluSrcA: aluAExcBase, writeAluOut: 1'b1, default: '0};
	localparam ctrlVecT jrV = '{aluSrcA: aluARegA, aluSrcB: aluBRegB, aluOp: aluLoad,
		writeAluOut: 1'b1, pcWrite: 1'b1, pcSource: pcAluResult, default: '0};
	localparam ctrlVecT breakV = '{aluSrcA: aluAPc, aluSrcB: aluBFour, aluOp: aluSub,
		pcWrite: 1'b1, default: '0};
	localparam ctrlVecT jalLinkV = '{memToReg: wbPc, default: '0};
	localparam ctrlVecT jalWait2V = '{writeMdr: 1'b1, default: '0};
	localparam ctrlVecT enableMask = '{writeMdr: 1'b1, irWrite: 1'b1, regWrite: 1'b1,
		writeA: 1'b1, writeB: 1'b1, writeAluOut: 1'b1, epcWrite: 1'b1, pcWrite: 1'b1,
		default: '0};

	// opcode and function code of each kind in instrKindT order
	localparam logic [5:0] kindOp [20] = '{opRType, opRType, opRType, opRType, opRType,
		opRType, opAddi, opAddiu, opJ, opJal, opBeq, opBne, opBle, opBgt,
		opRType, opRType, opRType, opRType, opRType, 6'h3f};
	localparam logic [5:0] kindFn [20] = '{fnAdd, fnSub, fnAnd, fnSlt, fnJr, fnBreak,
		6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00,
		fnSll, fnSllv, fnSra, fnSrav, fnSrl, 6'h00};

	function automatic ctrlVecT execV(logic [2:0] srcB, logic [2:0] op, logic [2:0] dst);
		return '{aluSrcA: aluARegA, aluSrcB: srcB, aluOp: op, regDst: dst,
			writeAluOut: 1'b1, default: '0};
	endfunction

	function automatic ctrlVecT writeV(logic [2:0] dst, logic [2:0] wb);
		return '{regWrite: 1'b1, regDst: dst, memToReg: wb, default: '0};
	endfunction

	function automatic ctrlVecT shiftV(logic [1:0] entry, logic [1:0] amount, logic [2:0] op);
		return '{disRegEntry: entry, disRegShamt: amount, disRegOp: op, default: '0};
	endfunction

	function automatic logic branchHolds(instrKindT kind, logic eqIn, logic gtIn);
		case (kind)
			kBeq: return eqIn;
			kBne: return !eqIn;
			kBle: return !gtIn;
			kBgt: return gtIn;
			default: return 1'b0;
		endcase
	endfunction

	// queues every cycle after fetch up to and including the next fetch
	task automatic queueInstr(input instrKindT kind, input logic ovf, input logic taken);
		logic [1:0] entry;
		logic [1:0] amount;
		logic [2:0] op;
		pending.push_back(quietV); // memory wait
		pending.push_back(irLoadV);
		pending.push_back(decodeV);
		case (kind)
			kAdd: pending.push_back(execV(aluBRegB, aluAdd, dstRt));
			kSub: pending.push_back(execV(aluBRegB, aluSub, dstRt));
			kAnd: pending.push_back(execV(aluBRegB, aluAnd, dstRt));
			kSlt: pending.push_back(execV(aluBRegB, aluCompare, dstRd));
			kAddi: pending.push_back(execV(aluBSignImm, aluAdd, dstRt));
			kAddiu: pending.push_back(execV(aluBZeroImm, aluAdd, dstRt));
			kJr: pending.push_back(jrV);
			kBreak: pending.push_back(breakV);
			kJ: pending.push_back(pcJumpV);
			kJal: begin // link, two waits, ra write, jump
				pending.push_back(jalLinkV);
				pending.push_back(quietV);
				pending.push_back(jalWait2V);
				pending.push_back(writeV(dstRa, wbPc));
				pending.push_back(pcJumpV);
			end
			kBeq, kBne, kBle, kBgt: begin
				pending.push_back(compareV);
				if (taken) begin
					pending.push_back(pcJumpV);
				end
			end
			kSll, kSllv, kSra, kSrav, kSrl: begin
				entry = (kind == kSllv || kind == kSrav) ? shInRegA : shInRegB;
				amount = (entry == shInRegA) ? shAmtReg : shAmtField;
				case (kind)
					kSll, kSllv: op = shLeft;
					kSrl: op = shRightLogic;
					default: op = shRightArith;
				endcase
				pending.push_back(shiftV(entry, shAmtField, shLoad));
				pending.push_back(shiftV(entry, amount, op));
				pending.push_back(writeV(dstRd, wbShift));
			end
			default: begin
			end
		endcase
		if (ovf && kind inside {kAdd, kSub, kAddi, kAddiu}) begin
			pending.push_back(overflowV);
			pending.push_back(causeLoadV);
			pending.push_back(pcJumpV);
		end else if (kind inside {kAdd, kSub, kAnd}) begin
			pending.push_back(writeV(dstRd, wbAluOut));
		end else if (kind == kSlt) begin
			pending.push_back(writeV(dstRd, wbLess));
		end else if (kind inside {kAddi, kAddiu}) begin
			pending.push_back(writeV(dstRt, wbAluOut));
		end
		pending.push_back(fetchV);
	endtask

	task automatic reportMismatch(input string what);
		$display("FAILED %0t: %s outputs differ, expected %h got %h", $time, what,
			expected, actual);
		$display("Finished with errors");
		$fatal(1, "output check failed");
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// expected outputs advance one entry per rising edge
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			expected <= writeV(dstSp, wbStackTop); // stack pointer init
		end else begin
			expected <= pending.pop_front();
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeoutCycles) begin
			$display("Timeout after %0d cycles, the instruction stream never finished",
				cycles);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	enablesMatch: assert property (@(negedge clk) ((actual ^ expected) & enableMask) == '0)
		else reportMismatch("write enable");
	selectsMatch: assert property (@(negedge clk) ((actual ^ expected) & ~enableMask) == '0)
		else reportMismatch("select");

	initial begin
		instrKindT kind;
		int issued;
		issued = 0;
		void'($urandom(32'hfefc_7751));
		reset = 1'b1;
		opCode = opRType;
		func = 6'h00;
		overflow = 1'b0;
		eq = 1'b0;
		gt = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		pending.push_back(fetchV);
		while (issued < numInstr) begin
			@(negedge clk);
			if (pcWrite && writeMdr) begin // fetch cycle
				kind = instrKindT'(5'($urandom_range(0, 19)));
				overflow = 1'($urandom_range(0, 1));
				eq = 1'($urandom_range(0, 1));
				gt = 1'($urandom_range(0, 1));
				opCode = kindOp[kind];
				func = kindFn[kind];
				if (opCode != opRType) begin
					func = 6'($urandom_range(0, 63)); // ignored outside R-type
				end
				if (kind == kUnknown && $urandom_range(0, 1) == 1) begin
					opCode = opRType;
					do begin
						func = 6'($urandom_range(0, 63));
					end while (func inside {fnSll, fnSrl, fnSra, fnSllv, fnSrav, fnJr,
						fnBreak, fnAdd, fnSub, fnAnd, fnSlt});
				end else if (kind == kUnknown) begin
					opCode = 6'($urandom_range(10, 63));
				end
				queueInstr(kind, overflow, branchHolds(kind, eq, gt));
				issued++;
			end
		end
		do begin
			@(negedge clk);
		end while (!(pcWrite && writeMdr)); // last instruction back in fetch
		#1;
		$display("Finished with no errors");
		$finish;
	end

endmodule
